// ==== common/drive_pkg.sv ====
`default_nettype none

package drive_pkg;

  // RAM word address
  typedef logic [9:0] addr_t;

  // Intensity, phase, modulation sample, pulse width and time count
  typedef logic [7:0] byte_t;

  typedef logic [7:0] chan_t;

  // Table RAM layout
  localparam addr_t PWE_BASE = 10'd0;
  localparam addr_t MOD_BASE = 10'd256;
  // Intensity at even offsets, phase right after it
  localparam addr_t CHAN_BASE = 10'd512;

  // Owner of the RAM port in a given cycle
  typedef enum logic [2:0] {
    arb_idle,
    arb_host,
    arb_pwe,
    arb_mod,
    arb_fetch
  } arb_state_e;

endpackage

`default_nettype wire

// ==== design/time_cnt_generator.sv ====
`timescale 1ns/1ps
`default_nettype none

module time_cnt_generator
  import drive_pkg::*;
(
  input  logic  clk,
  input  logic  arst_n,
  input  logic  run,
  output byte_t time_cnt,
  output logic  update
);

  logic run_d;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      run_d    <= 1'b0;
      time_cnt <= '0;
      update   <= 1'b0;
    end else begin
      run_d  <= run;
      // First cycle of a run or counter wrap
      update <= run && (!run_d || time_cnt == 8'hff);
      if (run && run_d) begin
        time_cnt <= time_cnt + 8'd1;
      end else begin
        time_cnt <= '0;
      end
    end
  end

endmodule

`default_nettype wire

// ==== design/table_memory/table_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module table_ram
  import drive_pkg::*;
(
  input  logic  clk,
  input  logic  en,
  input  logic  we,
  input  addr_t addr,
  input  byte_t wdata,
  output byte_t rdata
);

  localparam int WORDS = 2 ** $bits(addr_t);

  byte_t mem [WORDS];

  always_ff @(posedge clk) begin
    if (en) begin
      if (we) begin
        mem[addr] <= wdata;
      end
      rdata <= mem[addr];
    end
  end

endmodule

`default_nettype wire

// ==== design/table_memory/table_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module table_arbiter
  import drive_pkg::*;
(
  input  logic  clk,
  input  logic  arst_n,
  input  logic  host_we,
  input  addr_t host_addr,
  input  byte_t host_wdata,
  input  logic  pwe_req,
  input  addr_t pwe_addr,
  input  logic  mod_req,
  input  addr_t mod_addr,
  input  logic  fetch_req,
  input  addr_t fetch_addr,
  output logic  pwe_gnt,
  output logic  mod_gnt,
  output logic  fetch_gnt,
  output logic  pwe_rvalid,
  output logic  mod_rvalid,
  output logic  fetch_rvalid,
  output byte_t rdata
);

  arb_state_e sel;
  arb_state_e owner;
  addr_t      ram_addr;

  // Fixed priority, host first
  always_comb begin
    if (host_we) sel = arb_host;
    else if (pwe_req) sel = arb_pwe;
    else if (mod_req) sel = arb_mod;
    else if (fetch_req) sel = arb_fetch;
    else sel = arb_idle;
  end

  always_comb begin
    case (sel)
      arb_host: ram_addr = host_addr;
      arb_pwe:  ram_addr = pwe_addr;
      arb_mod:  ram_addr = mod_addr;
      default:  ram_addr = fetch_addr;
    endcase
  end

  assign pwe_gnt   = (sel == arb_pwe);
  assign mod_gnt   = (sel == arb_mod);
  assign fetch_gnt = (sel == arb_fetch);

  // Owner of the read that returns this cycle
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      owner <= arb_idle;
    end else begin
      owner <= sel;
    end
  end

  assign pwe_rvalid   = (owner == arb_pwe);
  assign mod_rvalid   = (owner == arb_mod);
  assign fetch_rvalid = (owner == arb_fetch);

  table_ram table_ram (
    .clk  (clk),
    .en   (sel != arb_idle),
    .we   (sel == arb_host),
    .addr (ram_addr),
    .wdata(host_wdata),
    .rdata(rdata)
  );

endmodule

`default_nettype wire

// ==== design/drive_fetch.sv ====
`timescale 1ns/1ps
`default_nettype none

module drive_fetch
  import drive_pkg::*;
#(
  parameter int DEPTH = 128
) (
  input  logic  clk,
  input  logic  arst_n,
  input  logic  update,
  output logic  fetch_req,
  output addr_t fetch_addr,
  input  logic  fetch_gnt,
  input  logic  fetch_rvalid,
  input  byte_t rdata,
  output logic  item_valid,
  output chan_t item_chan,
  output byte_t item_intensity,
  output byte_t item_phase
);

  // Two words per channel
  localparam logic [8:0] NREAD = 9'(2 * DEPTH);

  typedef enum logic {
    fetch_idle,
    fetch_busy
  } fetch_state_e;

  fetch_state_e state;
  logic [8:0]   issue_cnt;
  logic [8:0]   recv_cnt;
  byte_t        int_hold;

  assign fetch_req  = (state == fetch_busy) && (issue_cnt < NREAD);
  assign fetch_addr = CHAN_BASE + addr_t'(issue_cnt);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state      <= fetch_idle;
      issue_cnt  <= '0;
      recv_cnt   <= '0;
      item_valid <= 1'b0;
    end else begin
      // Phase word closes an item
      item_valid <= fetch_rvalid && recv_cnt[0];
      if (update) begin
        state     <= fetch_busy;
        issue_cnt <= '0;
        recv_cnt  <= '0;
      end else if (state == fetch_busy) begin
        if (fetch_gnt) begin
          issue_cnt <= issue_cnt + 9'd1;
        end
        if (fetch_rvalid) begin
          recv_cnt <= recv_cnt + 9'd1;
          if (recv_cnt == NREAD - 9'd1) begin
            state <= fetch_idle;
          end
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (fetch_rvalid) begin
      if (!recv_cnt[0]) begin
        int_hold <= rdata;
      end else begin
        item_chan      <= recv_cnt[8:1];
        item_intensity <= int_hold;
        item_phase     <= rdata;
      end
    end
  end

endmodule

`default_nettype wire

// ==== design/modulation.sv ====
`timescale 1ns/1ps
`default_nettype none

module modulation
  import drive_pkg::*;
(
  input  logic  clk,
  input  logic  arst_n,
  input  logic  run,
  input  logic  update,
  input  byte_t mod_cycle,
  output logic  mod_req,
  output addr_t mod_addr,
  input  logic  mod_gnt,
  input  logic  mod_rvalid,
  input  byte_t rdata,
  input  logic  item_valid,
  input  chan_t item_chan,
  input  byte_t item_intensity,
  input  byte_t item_phase,
  output logic  scaled_valid,
  output chan_t scaled_chan,
  output byte_t scaled_intensity,
  output byte_t scaled_phase
);

  logic        run_d;
  logic        pend;
  byte_t       idx;
  byte_t       idx_inc;
  byte_t       shadow_sample;
  byte_t       active_sample;
  logic [15:0] product;

  assign idx_inc  = idx + 8'd1;
  assign mod_req  = pend;
  assign mod_addr = MOD_BASE + addr_t'(idx);
  assign product  = item_intensity * active_sample;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      run_d        <= 1'b0;
      pend         <= 1'b0;
      idx          <= '0;
      scaled_valid <= 1'b0;
    end else begin
      run_d        <= run;
      scaled_valid <= item_valid;
      if (!run_d) begin
        // Keep sample 0 fresh while the host may still write
        idx  <= '0;
        pend <= 1'b1;
      end else if (update) begin
        idx  <= (idx_inc == mod_cycle) ? '0 : idx_inc;
        pend <= 1'b1;
      end else if (mod_gnt) begin
        pend <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (mod_rvalid) begin
      shadow_sample <= rdata;
    end
    // Sample 0 read can land with the first update itself
    if (update) begin
      active_sample <= mod_rvalid ? rdata : shadow_sample;
    end
    scaled_chan      <= item_chan;
    scaled_intensity <= product[15:8];
    scaled_phase     <= item_phase;
  end

endmodule

`default_nettype wire

// ==== design/pulse_width_lookup.sv ====
`timescale 1ns/1ps
`default_nettype none

module pulse_width_lookup
  import drive_pkg::*;
(
  input  logic  clk,
  input  logic  arst_n,
  input  logic  scaled_valid,
  input  chan_t scaled_chan,
  input  byte_t scaled_intensity,
  input  byte_t scaled_phase,
  output logic  pwe_req,
  output addr_t pwe_addr,
  input  logic  pwe_gnt,
  input  logic  pwe_rvalid,
  input  byte_t rdata,
  output logic  pw_valid,
  output chan_t pw_chan,
  output byte_t pw_width,
  output byte_t pw_phase
);

  chan_t chan_d;
  byte_t phase_d;

  // Top reader priority, so the request is taken at once
  assign pwe_req  = scaled_valid;
  assign pwe_addr = PWE_BASE + addr_t'(scaled_intensity);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pw_valid <= 1'b0;
    end else begin
      pw_valid <= pwe_rvalid;
    end
  end

  // Channel and phase ride along with the table read
  always_ff @(posedge clk) begin
    if (pwe_gnt) begin
      chan_d  <= scaled_chan;
      phase_d <= scaled_phase;
    end
    if (pwe_rvalid) begin
      pw_chan  <= chan_d;
      pw_phase <= phase_d;
      pw_width <= rdata;
    end
  end

endmodule

`default_nettype wire

// ==== design/pwm.sv ====
`timescale 1ns/1ps
`default_nettype none

module pwm
  import drive_pkg::*;
#(
  parameter int DEPTH = 128
) (
  input  logic             clk,
  input  logic             arst_n,
  input  logic             update,
  input  byte_t            time_cnt,
  input  logic             pw_valid,
  input  chan_t            pw_chan,
  input  byte_t            pw_width,
  input  byte_t            pw_phase,
  output logic [DEPTH-1:0] pwm_out
);

  byte_t      width_shadow [DEPTH];
  byte_t      phase_shadow [DEPTH];
  byte_t      width_active [DEPTH];
  byte_t      phase_active [DEPTH];
  logic       idle;
  logic       use_shadow;
  byte_t      t_next;
  logic [DEPTH-1:0] next_out;

  // Counter parked at 0 without update means run is low
  assign idle       = (time_cnt == '0) && !update;
  assign t_next     = time_cnt + 8'd1;
  // Next cycle already belongs to the new period
  assign use_shadow = update || (time_cnt == 8'hff);

  always_ff @(posedge clk) begin
    for (int c = 0; c < DEPTH; c++) begin
      if (idle) begin
        width_shadow[c] <= '0;
        width_active[c] <= '0;
      end else begin
        if (pw_valid && pw_chan == chan_t'(c)) begin
          width_shadow[c] <= pw_width;
          phase_shadow[c] <= pw_phase;
        end
        if (update) begin
          width_active[c] <= width_shadow[c];
          phase_active[c] <= phase_shadow[c];
        end
      end
    end
  end

  // Output for the coming count value
  always_comb begin
    for (int c = 0; c < DEPTH; c++) begin
      if (use_shadow) begin
        next_out[c] = byte_t'(t_next - phase_shadow[c]) < width_shadow[c];
      end else begin
        next_out[c] = byte_t'(t_next - phase_active[c]) < width_active[c];
      end
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pwm_out <= '0;
    end else begin
      pwm_out <= idle ? '0 : next_out;
    end
  end

endmodule

`default_nettype wire

// ==== design/drive_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module drive_top
  import drive_pkg::*;
#(
  parameter int DEPTH = 128
) (
  input  logic             clk,
  input  logic             arst_n,
  input  logic             run,
  input  byte_t            mod_cycle,
  input  logic             host_we,
  input  addr_t            host_addr,
  input  byte_t            host_wdata,
  output logic [DEPTH-1:0] pwm_out
);

  byte_t time_cnt;
  logic  update;
  byte_t rdata;

  logic  pwe_req, pwe_gnt, pwe_rvalid;
  logic  mod_req, mod_gnt, mod_rvalid;
  logic  fetch_req, fetch_gnt, fetch_rvalid;
  addr_t pwe_addr, mod_addr, fetch_addr;

  logic  item_valid;
  chan_t item_chan;
  byte_t item_intensity, item_phase;

  logic  scaled_valid;
  chan_t scaled_chan;
  byte_t scaled_intensity, scaled_phase;

  logic  pw_valid;
  chan_t pw_chan;
  byte_t pw_width, pw_phase;

  time_cnt_generator time_cnt_generator (
    .clk(clk), .arst_n(arst_n), .run(run), .time_cnt(time_cnt), .update(update)
  );

  table_arbiter table_arbiter (
    .clk(clk), .arst_n(arst_n),
    .host_we(host_we), .host_addr(host_addr), .host_wdata(host_wdata),
    .pwe_req(pwe_req), .pwe_addr(pwe_addr),
    .mod_req(mod_req), .mod_addr(mod_addr),
    .fetch_req(fetch_req), .fetch_addr(fetch_addr),
    .pwe_gnt(pwe_gnt), .mod_gnt(mod_gnt), .fetch_gnt(fetch_gnt),
    .pwe_rvalid(pwe_rvalid), .mod_rvalid(mod_rvalid), .fetch_rvalid(fetch_rvalid),
    .rdata(rdata)
  );

  drive_fetch #(
    .DEPTH(DEPTH)
  ) drive_fetch (
    .clk(clk), .arst_n(arst_n), .update(update),
    .fetch_req(fetch_req), .fetch_addr(fetch_addr),
    .fetch_gnt(fetch_gnt), .fetch_rvalid(fetch_rvalid), .rdata(rdata),
    .item_valid(item_valid), .item_chan(item_chan),
    .item_intensity(item_intensity), .item_phase(item_phase)
  );

  modulation modulation (
    .clk(clk), .arst_n(arst_n), .run(run), .update(update), .mod_cycle(mod_cycle),
    .mod_req(mod_req), .mod_addr(mod_addr),
    .mod_gnt(mod_gnt), .mod_rvalid(mod_rvalid), .rdata(rdata),
    .item_valid(item_valid), .item_chan(item_chan),
    .item_intensity(item_intensity), .item_phase(item_phase),
    .scaled_valid(scaled_valid), .scaled_chan(scaled_chan),
    .scaled_intensity(scaled_intensity), .scaled_phase(scaled_phase)
  );

  pulse_width_lookup pulse_width_lookup (
    .clk(clk), .arst_n(arst_n),
    .scaled_valid(scaled_valid), .scaled_chan(scaled_chan),
    .scaled_intensity(scaled_intensity), .scaled_phase(scaled_phase),
    .pwe_req(pwe_req), .pwe_addr(pwe_addr),
    .pwe_gnt(pwe_gnt), .pwe_rvalid(pwe_rvalid), .rdata(rdata),
    .pw_valid(pw_valid), .pw_chan(pw_chan), .pw_width(pw_width), .pw_phase(pw_phase)
  );

  pwm #(
    .DEPTH(DEPTH)
  ) pwm (
    .clk(clk), .arst_n(arst_n), .update(update), .time_cnt(time_cnt),
    .pw_valid(pw_valid), .pw_chan(pw_chan), .pw_width(pw_width), .pw_phase(pw_phase),
    .pwm_out(pwm_out)
  );

endmodule

`default_nettype wire

// ==== test/drive_chk.sv ====
`timescale 1ns/1ps
`default_nettype none

module drive_chk (
  input logic clk,
  input logic arst_n,
  input logic run,
  input logic host_we,
  input logic pwe_gnt,
  input logic mod_gnt,
  input logic fetch_gnt,
  input logic pwe_rvalid,
  input logic mod_rvalid,
  input logic fetch_rvalid
);

  int fail_cnt = 0;

  // A host write takes the RAM port like a grant
  one_grant: assert property (@(posedge clk) disable iff (!arst_n)
    $onehot0({host_we, pwe_gnt, mod_gnt, fetch_gnt}))
    else begin
      $error("more than one RAM owner in a cycle");
      fail_cnt++;
    end

  rvalid_after_gnt: assert property (@(posedge clk) disable iff (!arst_n)
    {pwe_rvalid, mod_rvalid, fetch_rvalid} == $past({pwe_gnt, mod_gnt, fetch_gnt}))
    else begin
      $error("read data flag does not follow its grant by one cycle");
      fail_cnt++;
    end

  write_when_halted: assert property (@(posedge clk) disable iff (!arst_n)
    host_we |-> !run)
    else begin
      $error("host write while run is high");
      fail_cnt++;
    end

endmodule

`default_nettype wire

// ==== test/drive_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module drive_tb
  import drive_pkg::*;
();

  localparam int DEPTH = 4;
  localparam int NCASE = 5;
  localparam int WRITES = 512 + 2 * DEPTH;

  // mod_mode 0 is random, 1 all 255 and 2 a distinct ramp
  // pwe_mode 0 is random and 1 identity
  // A pwe_zero above 255 clears no extra entry
  typedef struct packed {
    int                    mod_cycle;
    int                    periods;
    int                    mod_mode;
    int                    pwe_mode;
    int                    pwe_zero;
    logic [DEPTH-1:0]      ovr_en;
    logic [DEPTH-1:0][7:0] ovr_int;
    logic [DEPTH-1:0][7:0] ovr_phase;
  } case_t;

  // Overrides listed from channel 3 down to channel 0
  case_t cases [NCASE] = '{
    '{1, 3, 1, 0, 256, 4'b1111, {8'd255, 8'd255, 8'd255, 8'd255}, {8'd200, 8'd128, 8'd64, 8'd0}},
    '{3, 6, 2, 1, 256, 4'b1111, {8'd255, 8'd180, 8'd255, 8'd255}, {8'd30, 8'd90, 8'd0, 8'd10}},
    '{1, 3, 1, 1, 256, 4'b0111, {8'd0, 8'd255, 8'd200, 8'd255}, {8'd0, 8'd255, 8'd240, 8'd250}},
    '{1, 3, 1, 0, 254, 4'b0011, {8'd0, 8'd0, 8'd255, 8'd0}, {8'd0, 8'd0, 8'd30, 8'd10}},
    '{4, 6, 0, 0, 256, 4'b0000, 32'd0, 32'd0}
  };
  string names [NCASE] = '{"full_on", "mod_steps", "phase_wrap", "zero_out", "restart_random"};

  logic             clk;
  logic             arst_n;
  logic             run;
  byte_t            mod_cycle;
  logic             host_we;
  addr_t            host_addr;
  byte_t            host_wdata;
  logic [DEPTH-1:0] pwm_out;

  integer seed = 42;
  longint cycles = 0;
  longint limit;
  byte_t  pwe_tab [256];
  byte_t  mod_tab [256];
  byte_t  ch_int [DEPTH];
  byte_t  ch_phase [DEPTH];

  drive_top #(
    .DEPTH(DEPTH)
  ) uut (
    .clk(clk), .arst_n(arst_n), .run(run), .mod_cycle(mod_cycle),
    .host_we(host_we), .host_addr(host_addr), .host_wdata(host_wdata),
    .pwm_out(pwm_out)
  );

  bind drive_top drive_chk chk (
    .clk(clk), .arst_n(arst_n), .run(run), .host_we(host_we),
    .pwe_gnt(pwe_gnt), .mod_gnt(mod_gnt), .fetch_gnt(fetch_gnt),
    .pwe_rvalid(pwe_rvalid), .mod_rvalid(mod_rvalid), .fetch_rvalid(fetch_rvalid)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Simulation finished: FAIL");
    $fatal(1, "Run stopped early");
  endtask

  task automatic compare_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
    if (expected !== actual) begin
      abort_run($sformatf("Error: %s expected %0h actual %0h", name, expected, actual));
    end
  endtask

  function automatic longint cycle_limit();
    longint total;
    total = 16;
    for (int k = 0; k < NCASE; k++) begin
      total += (cases[k].periods + 2) * 256 + WRITES;
    end
    return total * 3 / 2;
  endfunction

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= limit) begin
      abort_run("Timeout: the tests did not finish within the cycle limit");
    end else if (uut.chk.fail_cnt != 0) begin
      abort_run("Checker assertion failed on the table arbiter");
    end
  end

  task automatic fill_tables(input case_t cs);
    for (int i = 0; i < 256; i++) begin
      pwe_tab[i] = (cs.pwe_mode == 1) ? byte_t'(i) : byte_t'($random(seed));
      case (cs.mod_mode)
        1: mod_tab[i] = 8'd255;
        2: mod_tab[i] = byte_t'(40 + 85 * i);
        default: mod_tab[i] = byte_t'($random(seed));
      endcase
    end
    // Zero intensity gives zero width
    pwe_tab[0] = 8'd0;
    if (cs.pwe_zero < 256) begin
      pwe_tab[cs.pwe_zero] = 8'd0;
    end
    for (int c = 0; c < DEPTH; c++) begin
      ch_int[c]   = cs.ovr_en[c] ? cs.ovr_int[c] : byte_t'($random(seed));
      ch_phase[c] = cs.ovr_en[c] ? cs.ovr_phase[c] : byte_t'($random(seed));
    end
  endtask

  task automatic write_word(input addr_t a, input byte_t d);
    host_we    = 1'b1;
    host_addr  = a;
    host_wdata = d;
    @(posedge clk);
    #1;
  endtask

  task automatic write_tables();
    for (int i = 0; i < 256; i++) begin
      write_word(PWE_BASE + addr_t'(i), pwe_tab[i]);
      write_word(MOD_BASE + addr_t'(i), mod_tab[i]);
    end
    for (int c = 0; c < DEPTH; c++) begin
      write_word(CHAN_BASE + addr_t'(2 * c), ch_int[c]);
      write_word(CHAN_BASE + addr_t'(2 * c + 1), ch_phase[c]);
    end
    host_we = 1'b0;
  endtask

  // Period p shows the items fetched after update p-1
  function automatic logic [DEPTH-1:0] expected_out(input int period, input int t,
                                                    input int cyc);
    logic [DEPTH-1:0] v;
    int               m;
    int               scaled;
    int               w;
    v = '0;
    if (period > 0) begin
      m = mod_tab[(period - 1) % cyc];
      for (int c = 0; c < DEPTH; c++) begin
        scaled = (int'(ch_int[c]) * m) / 256;
        w      = pwe_tab[scaled];
        v[c]   = ((t - int'(ch_phase[c])) & 255) < w;
      end
    end
    return v;
  endfunction

  task automatic run_case(input int k);
    case_t            cs;
    logic [DEPTH-1:0] exp_v;
    cs = cases[k];
    fill_tables(cs);
    mod_cycle = byte_t'(cs.mod_cycle);
    write_tables();
    repeat (2) @(posedge clk);
    #1;
    run = 1'b1;
    for (int n = 0; n < cs.periods * 256; n++) begin
      @(posedge clk);
      #1;
      exp_v = expected_out(n / 256, n % 256, cs.mod_cycle);
      compare_value($sformatf("%s period %0d count %0d", names[k], n / 256, n % 256),
                    32'(exp_v), 32'(pwm_out));
    end
    run = 1'b0;
    repeat (2) @(posedge clk);
    #1;
  endtask

  initial begin
    arst_n     = 1'b0;
    run        = 1'b0;
    mod_cycle  = 8'd1;
    host_we    = 1'b0;
    host_addr  = '0;
    host_wdata = '0;
    limit      = cycle_limit();
    repeat (3) @(posedge clk);
    #1;
    arst_n = 1'b1;
    for (int k = 0; k < NCASE; k++) begin
      run_case(k);
    end
    if (uut.chk.fail_cnt == 0) begin
      $display("Simulation finished: PASS");
      $finish;
    end else begin
      abort_run("Checker assertion failed on the table arbiter");
    end
  end

endmodule

`default_nettype wire

// ==== src.f ====
common/drive_pkg.sv
design/time_cnt_generator.sv
design/table_memory/table_ram.sv
design/table_memory/table_arbiter.sv
design/drive_fetch.sv
design/modulation.sv
design/pulse_width_lookup.sv
design/pwm.sv
design/drive_top.sv
test/drive_chk.sv
test/drive_tb.sv

// ==== Bender.yml ====
package:
  name: ultrasound_drive

sources:
  - common/drive_pkg.sv
  - design/time_cnt_generator.sv
  - design/table_memory/table_ram.sv
  - design/table_memory/table_arbiter.sv
  - design/drive_fetch.sv
  - design/modulation.sv
  - design/pulse_width_lookup.sv
  - design/pwm.sv
  - design/drive_top.sv
  - target: test
    files:
      - test/drive_chk.sv
      - test/drive_tb.sv
